/* Bender.yml */
package:
  name: flashIo

sources:
  # packages first, the rtl depends on them
  - verilog/ioBusPkg.sv
  - verilog/spiPkg.sv
  - verilog/ioDecode.sv
  - verilog/spiMaster.sv
  - verilog/ioResult.sv
  - verilog/flashIo.sv

  - target: simulation
    files:
      - verification/flashModel.sv
      - verification/flashIo_sva.sv
      - verification/flashIo_tb.sv

/* build.f */
verilog/ioBusPkg.sv
verilog/spiPkg.sv
verilog/ioDecode.sv
verilog/spiMaster.sv
verilog/ioResult.sv
verilog/flashIo.sv
verification/flashModel.sv
verification/flashIo_sva.sv
verification/flashIo_tb.sv

/* verification/flashIo_sva.sv */
module flashIo_sva (
	input logic clk,
	input logic rst,
	input logic cfgDone,
	input logic busy,
	input logic startXfer, // accepted write that sends a byte
	input logic [spiPkg::countWidth-1:0] count, // half cycle counter
	input spiPkg::spiPins pins
);
	timeunit 1ns;
	timeprecision 1ps;

	int failCount = 0; // failed assertions so far

	// counter parked at zero while idle, so every byte starts with sck low
	sckIdle: assert property (@(posedge clk) disable iff (rst) !busy |-> count == '0)
		else begin
			$error("half cycle counter not at zero while the engine is idle");
			failCount++;
		end

	// busy holds for 16 half cycles and drops on the 17th cycle
	busyLength: assert property (@(posedge clk) disable iff (rst)
		startXfer |=> busy [*spiPkg::halfCycles] ##1 !busy)
		else begin
			$error("busy did not fall 17 cycles after a transfer start");
			failCount++;
		end

	// flash stays selected for the whole byte once the fabric is configured
	csxHeld: assert property (@(posedge clk) disable iff (rst || !cfgDone)
		startXfer |=> !pins.csx [*spiPkg::halfCycles])
		else begin
			$error("csx rose in the middle of a transfer");
			failCount++;
		end

endmodule

bind spiMaster flashIo_sva sva0 (
	.clk(clk),
	.rst(rst),
	.cfgDone(cfgDone),
	.busy(busy),
	.startXfer(startXfer),
	.count(count),
	.pins(pins)
);

/* verification/flashIo_tb.sv */
module flashIo_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int maxOps = 64; // room in the operation table
	localparam logic [3:0] opWrite = 4'h0;
	localparam logic [3:0] opRead = 4'h1; // spi reads poll busy first
	localparam logic [3:0] opPins = 4'h2;
	localparam logic [3:0] opEnd = 4'hF; // fill value past the last line
	localparam int cyclesPerOp = 40;
	localparam int spareCycles = 100; // reset and final cycles

	logic clk;
	logic rst;
	logic cfgDone;
	ioBusPkg::busReq req;
	logic sdi; // miso from the flash model
	spiPkg::spiPins pins;
	logic [15:0] rdata;
	logic [7:0] leds;

	logic [35:0] ops [maxOps]; // op, address and data of one line
	int opCount = 0;

	flashIo dut0 (
		.clk(clk),
		.rst(rst),
		.cfgDone(cfgDone),
		.req(req),
		.sdi(sdi),
		.pins(pins),
		.rdata(rdata),
		.leds(leds)
	);

	flashModel flash0 (
		.pins(pins),
		.miso(sdi)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk; // 10 ns period
		end
	end

	task automatic stopRun(input string why);
		$display("Simulation FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic checkStatus(input string name, input spiPkg::spiStatus expected,
			input spiPkg::spiStatus actual);
		if (actual !== expected) begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			stopRun("status mismatch");
		end
	endtask

	task automatic checkLed(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			stopRun("byte mismatch");
		end
	endtask

	task automatic checkPins(input string name, input spiPkg::spiPins expected,
			input spiPkg::spiPins actual);
		if (actual !== expected) begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			stopRun("pin mismatch");
		end
	endtask

	// one cycle write strobe, inputs change on the falling edge
	task automatic busWrite(input logic [15:0] addr, input logic [15:0] data);
		@(negedge clk);
		req.addr = addr;
		req.wdata = data;
		req.we = 1'b1;
		@(negedge clk);
		req.we = 1'b0;
		req.addr = 16'h0000; // park on an unmapped address
	endtask

	task automatic busRead(input logic [15:0] addr, input logic [15:0] expected);
		spiPkg::spiStatus status;
		@(negedge clk);
		req.addr = addr;
		req.we = 1'b0;
		@(negedge clk); // rdata answers one cycle after the address
		if (addr == ioBusPkg::spiAddr) begin
			status = rdata;
			while (status.busy) begin
				@(negedge clk);
				status = rdata;
			end
			checkStatus("rdata", expected, status);
		end else begin
			checkLed("rdata[15:8]", expected[15:8], rdata[15:8]);
			checkLed("rdata[7:0]", expected[7:0], rdata[7:0]);
			if (addr == ioBusPkg::ledAddr) begin
				checkLed("leds", expected[7:0], leds); // pins match the register
			end
		end
	endtask

	// watchdog, limit scales with the number of operations
	initial begin : watchdog
		int limit;
		wait (opCount > 0);
		limit = opCount * cyclesPerOp + spareCycles;
		repeat (limit) @(posedge clk);
		$display("timeout: operations not finished after %0d cycles", limit);
		stopRun("watchdog expired");
	end

	// first failed assertion in the bound checker ends the run
	initial begin : assertWatch
		wait (dut0.spi0.sva0.failCount != 0);
		$display("an assertion in the spi engine failed");
		stopRun("assertion failed");
	end

	initial begin : stimulus
		logic [3:0] op;
		logic [15:0] addr;
		logic [15:0] data;
		int i;

		rst = 1'b1;
		cfgDone = 1'b0; // fabric still configuring
		req = '0;
		for (i = 0; i < maxOps; i++) begin
			ops[i] = {opEnd, 32'(i)};
		end
		$readmemh("verification/spi_input.txt", ops);
		while (opCount < maxOps && ops[opCount][35:32] != opEnd) begin
			opCount++;
		end
		if (opCount == 0) begin
			$display("no operations found in verification/spi_input.txt");
			stopRun("empty stimulus file");
		end

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		cfgDone = 1'b1;

		for (i = 0; i < opCount; i++) begin
			{op, addr, data} = ops[i];
			case (op)
				opWrite: begin
					busWrite(addr, data);
				end
				opRead: begin
					busRead(addr, data);
				end
				opPins: begin
					checkPins("pins", spiPkg::spiPins'(data[2:0]), pins); // {sck, csx, sdo}
				end
				default: begin
					$display("unknown operation code %0d on entry %0d", op, i);
					stopRun("bad stimulus entry");
				end
			endcase
		end

		@(negedge clk);
		if (dut0.spi0.sva0.failCount == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("%0d assertion failures in the spi engine", dut0.spi0.sva0.failCount);
			stopRun("assertions failed");
		end
	end

endmodule

/* verification/flashModel.sv */
module flashModel (
	input spiPkg::spiPins pins, // sck, csx and mosi from the dut
	output logic miso
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [7:0] readCmd = 8'h03; // plain read command
	localparam logic [7:0] dataMask = 8'h5A; // data byte is address low byte xor this
	localparam logic [7:0] idleByte = 8'hFF; // returned before data starts

	logic sck;
	logic csx;
	logic mosi;
	logic [7:0] cmd; // first byte after csx falls
	logic [23:0] addr; // three address bytes, msb first
	logic [7:0] inReg; // mosi shift in
	logic [7:0] outReg; // miso shift out, msb on the pin
	int bitCount; // bits of the current byte seen on sck rise
	int byteCount; // bytes finished since csx fell

	assign sck = pins.sck;
	assign csx = pins.csx;
	assign mosi = pins.sdo;
	assign miso = outReg[7];

	// state of a deselected flash
	task restart();
		cmd = 8'h00;
		addr = 24'h000000;
		inReg = 8'h00;
		outReg = idleByte;
		bitCount = 0;
		byteCount = 0;
	endtask

	initial begin
		restart();
	end

	always @(posedge sck or negedge sck or posedge csx) begin
		if (csx !== 1'b0) begin
			restart(); // csx high ends any command
		end else if (sck === 1'b1) begin
			inReg = {inReg[6:0], mosi}; // sample on the rise
			bitCount++;
		end else if (bitCount == 8) begin
			// last fall of a byte, decode it and load the next answer
			if (byteCount == 0) begin
				cmd = inReg;
			end else if (byteCount <= 3) begin
				addr = {addr[15:0], inReg};
			end
			if (cmd == readCmd && byteCount >= 3) begin
				outReg = addr[7:0] ^ dataMask;
				addr = addr + 24'd1; // sequential read
			end else begin
				outReg = idleByte;
			end
			byteCount++;
			bitCount = 0;
		end else begin
			outReg = {outReg[6:0], 1'b1}; // next bit onto miso
		end
	end

endmodule

/* verification/spi_input.txt */
// op_addr_data per line, op 0 write, 1 read and compare, 2 check pins {sck,csx,sdo}
// spi reads poll until busy is clear, then compare the whole status word
2_0000_0002
1_6001_0000
1_6002_0000
0_6002_00A5
1_6002_00A5
1_1234_0000
1_6000_0000
// read command at 0x000010
0_6001_0003
1_6001_00FF
0_6001_0000
1_6001_00FF
0_6001_0000
1_6001_00FF
0_6001_0010
1_6001_00FF
0_6001_0000
1_6001_004A
0_6001_0000
1_6001_004B
0_6001_0000
1_6001_0048
// raise csx, rx byte kept
0_6001_0100
2_0000_0002
1_6001_0048
// second command at 0x0000FE
0_6001_0003
1_6001_00FF
0_6001_0000
1_6001_00FF
0_6001_0000
1_6001_00FF
0_6001_00FE
1_6001_00FF
0_6001_0000
1_6001_00A4
0_6001_0000
1_6001_00A5
0_6001_0000
1_6001_005A
// second write lands while busy and is dropped
0_6001_0000
0_6001_0033
1_6001_005B
0_6001_0000
1_6001_0058
0_6001_0100
2_0000_0002
1_6002_00A5

/* verilog/flashIo.sv */
module flashIo (
	input logic clk,
	input logic rst,
	input logic cfgDone, // held low until the fabric is configured
	input ioBusPkg::busReq req, // cpu bus, one request per cycle
	input logic sdi, // miso
	output spiPkg::spiPins pins, // sck, csx, mosi
	output logic [ioBusPkg::dataWidth-1:0] rdata, // valid the cycle after the address
	output logic [ioBusPkg::ledWidth-1:0] leds
);

	ioBusPkg::devStrobes strobes; // write pulses and data
	ioBusPkg::rdSel sel;
	spiPkg::spiStatus status;

	// address decode
	ioDecode decode0 (
		.clk(clk),
		.rst(rst),
		.req(req),
		.strobes(strobes),
		.sel(sel)
	);

	// spi engine
	spiMaster spi0 (
		.clk(clk),
		.rst(rst),
		.cfgDone(cfgDone),
		.strobes(strobes),
		.sdi(sdi),
		.pins(pins),
		.status(status)
	);

	// leds and read data
	ioResult result0 (
		.clk(clk),
		.rst(rst),
		.strobes(strobes),
		.sel(sel),
		.status(status),
		.rdata(rdata),
		.leds(leds)
	);

endmodule

/* verilog/ioBusPkg.sv */
package ioBusPkg;

	// word addresses of the memory mapped registers
	localparam logic [15:0] spiAddr = 16'h6001; // spi data and status
	localparam logic [15:0] ledAddr = 16'h6002; // led output register

	localparam int dataWidth = 16; // cpu word
	localparam int ledWidth = 8;

	// one bus cycle from the cpu
	typedef struct packed {
		logic [15:0] addr;
		logic [dataWidth-1:0] wdata;
		logic we; // single cycle write strobe
	} busReq;

	// registered read select, picks the word returned one cycle later
	typedef enum logic [1:0] {
		none = 2'd0, // unmapped address reads as zero
		spi = 2'd1,
		led = 2'd2
	} rdSel;

	// decoded write pulses for the devices
	typedef struct packed {
		logic spiWr;
		logic ledWr;
		logic [dataWidth-1:0] wdata; // write data shared by both devices
	} devStrobes;

endpackage

/* verilog/ioDecode.sv */
module ioDecode (
	input logic clk,
	input logic rst,
	input ioBusPkg::busReq req,
	output ioBusPkg::devStrobes strobes,
	output ioBusPkg::rdSel sel
);

	logic spiHit; // address matches the spi register
	logic ledHit;
	ioBusPkg::rdSel selNext;

	// address compare, full 16 bit match
	assign spiHit = (req.addr == ioBusPkg::spiAddr);
	assign ledHit = (req.addr == ioBusPkg::ledAddr);

	// write pulses only exist for the cycle that carries we
	assign strobes.spiWr = req.we & spiHit;
	assign strobes.ledWr = req.we & ledHit;
	assign strobes.wdata = req.wdata; // devices pick their own fields

	// select for the read word
	always_comb begin
		if (spiHit) begin
			selNext = ioBusPkg::spi;
		end else if (ledHit) begin
			selNext = ioBusPkg::led;
		end else begin
			selNext = ioBusPkg::none; // anything else reads zero
		end
	end

	// the read answers in the following cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= ioBusPkg::none;
		end else begin
			sel <= selNext;
		end
	end

endmodule

/* verilog/ioResult.sv */
module ioResult (
	input logic clk,
	input logic rst,
	input ioBusPkg::devStrobes strobes,
	input ioBusPkg::rdSel sel, // already one cycle behind the address
	input spiPkg::spiStatus status,
	output logic [ioBusPkg::dataWidth-1:0] rdata,
	output logic [ioBusPkg::ledWidth-1:0] leds
);

	logic [ioBusPkg::ledWidth-1:0] ledReg;

	// led register takes the low byte of the write word
	always_ff @(posedge clk) begin
		if (rst) begin
			ledReg <= '0; // leds dark after reset
		end else if (strobes.ledWr) begin
			ledReg <= strobes.wdata[ioBusPkg::ledWidth-1:0];
		end
	end

	assign leds = ledReg;

	// read word selected by the registered select
	// every source here is a flop so rdata is clean
	always_comb begin
		case (sel)
			ioBusPkg::spi: begin
				rdata = status; // busy in bit 15, rx byte below
			end
			ioBusPkg::led: begin
				rdata = {{(ioBusPkg::dataWidth - ioBusPkg::ledWidth){1'b0}}, ledReg};
			end
			default: begin
				rdata = '0; // unmapped
			end
		endcase
	end

endmodule

/* verilog/spiMaster.sv */
module spiMaster (
	input logic clk,
	input logic rst,
	input logic cfgDone, // fabric configuration done
	input ioBusPkg::devStrobes strobes,
	input logic sdi, // miso from the flash
	output spiPkg::spiPins pins,
	output spiPkg::spiStatus status
);

	spiPkg::spiCmd cmd; // write word viewed as a command
	logic start; // accepted write to the data register
	logic startXfer; // accepted write that sends a byte
	logic csReg; // chip select as last written
	logic busy; // transfer in progress
	logic [spiPkg::countWidth-1:0] count; // half cycle counter
	logic done; // last half cycle of a transfer
	logic sampleEn;
	logic shiftEn;
	logic misoSample; // miso captured as sck rises
	logic [spiPkg::byteWidth-1:0] shiftReg; // tx byte out, rx byte in

	assign cmd = spiPkg::spiCmd'(strobes.wdata);

	// software polls busy, a write during a transfer is dropped
	assign start = strobes.spiWr & ~busy;
	assign startXfer = start & ~cmd.csHigh;

	assign done = busy & (count == spiPkg::lastCount);

	// even counts have sck low and it rises at the end of them
	assign sampleEn = busy & ~count[0];
	// odd counts have sck high, the edge that ends them is the fall
	assign shiftEn = busy & count[0];

	// chip select follows bit 8 of every accepted write
	// low to send a byte, high to end a flash command
	always_ff @(posedge clk) begin
		if (rst) begin
			csReg <= 1'b1; // flash deselected out of reset
		end else if (start) begin
			csReg <= cmd.csHigh;
		end
	end

	// busy is set by a byte write and cleared after 16 half cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
		end else if (startXfer) begin
			busy <= 1'b1;
		end else if (done) begin
			busy <= 1'b0;
		end
	end

	// counter runs only while busy and wraps to zero with done
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (done) begin
			count <= '0; // ready for the next byte
		end else if (busy) begin
			count <= count + 1'b1;
		end
	end

	// flash drives miso on sck fall, so it is stable at the rise
	always_ff @(posedge clk) begin
		if (sampleEn) begin
			misoSample <= sdi;
		end
	end

	// circular buffer, tx msb leaves on mosi while rx bit enters the lsb
	// eight shifts per byte, the last one lands with done
	always_ff @(posedge clk) begin
		if (rst) begin
			shiftReg <= '0; // status reads zero after reset
		end else if (startXfer) begin
			shiftReg <= cmd.txByte; // csHigh writes keep the last rx byte
		end else if (shiftEn) begin
			shiftReg <= {shiftReg[spiPkg::byteWidth-2:0], misoSample};
		end
	end

	// sck at half the clk rate, high on odd counts only
	assign pins.sck = busy & count[0];
	// mosi changes on the same edge that drops sck
	assign pins.sdo = busy & shiftReg[spiPkg::byteWidth-1];
	// keep the flash deselected until the fabric is configured
	assign pins.csx = cfgDone ? csReg : 1'b1;

	assign status.busy = busy; // bit 15
	assign status.zero = '0;
	assign status.rxByte = shiftReg; // partial while busy

endmodule

/* verilog/spiPkg.sv */
package spiPkg;

	localparam int byteWidth = 8; // bits per spi transfer

	// two clk cycles per sck period, eight periods per byte
	localparam int halfCycles = 16;
	localparam int countWidth = 4;

	// count value on the last half cycle, busy drops after it
	localparam logic [countWidth-1:0] lastCount = countWidth'(halfCycles - 1);

	// cpu write word as seen by the spi engine
	typedef struct packed {
		logic [6:0] reserved;
		logic csHigh; // set to raise csx and send nothing
		logic [byteWidth-1:0] txByte; // byte shifted out on mosi
	} spiCmd;

	// word returned on a status read
	typedef struct packed {
		logic busy; // bit 15
		logic [6:0] zero;
		logic [byteWidth-1:0] rxByte; // last byte received from miso
	} spiStatus;

	// pins toward the flash
	typedef struct packed {
		logic sck; // idles low
		logic csx; // active low chip select
		logic sdo; // mosi
	} spiPins;

endpackage
